/* filelist.f */
+incdir+.
conv_types_pkg.sv
wb_bus_pkg.sv
tap_bus_if.sv
conv_wb_regs.sv
conv_kernel_buffer.sv
conv_window_buffer.sv
conv_mac_unit.sv
conv3x3_engine.sv
tb_clock_gen.sv
conv3x3_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module conv3x3_engine_tb \
	-Mdir obj_dir -o sim_conv3x3

output="$(./obj_dir/sim_conv3x3)"
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

/* conv3x3_engine_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv3x3_engine_tb;
	import conv_types_pkg::*;
	import wb_bus_pkg::*;

	localparam int W = `CONV_DATA_WIDTH;
	localparam int TAPS = `CONV_KERNEL_SIZE;
	localparam int KBITS = W * TAPS;
	localparam int ACK_LIMIT = 50;
	localparam int DONE_LIMIT = 40;
	localparam int STALL_LIMIT = 20;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;
	logic done;

	// Reference state of the engine
	logic [31:0] lfsr_state;
	logic [KBITS-1:0] ref_sets [$];
	logic [KBITS-1:0] pend_set;
	int pend_count;
	logic [KBITS-1:0] ref_active;
	logic [KBITS-1:0] ref_window;
	logic ref_loaded;
	logic ref_done;

	// Pending comparisons for the checker
	string chk_name [$];
	wb_data_t chk_exp [$];
	wb_data_t chk_act [$];
	string cur_name;
	wb_data_t cur_exp;
	wb_data_t cur_act;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	int tests_run;

	tb_clock_gen #(
		.PERIOD_NS(100),
		.RESET_CYCLES(16)
	) clock_inst (
		.clk(clk),
		.reset(reset)
	);

	conv3x3_engine conv3x3_engine_inst (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.done(done)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Sum of nine signed products, wraps at 32 bits
	function automatic acc_t conv_ref(input logic [KBITS-1:0] kernel,
		input logic [KBITS-1:0] pixels);
		acc_t sum;
		logic signed [2*W-1:0] prod;
		sum = '0;
		for (int i = 0; i < TAPS; i++) begin
			prod = $signed(kernel[i*W +: W]) * $signed(pixels[i*W +: W]);
			sum = sum + acc_t'(prod);
		end
		return sum;
	endfunction

	function automatic wb_data_t expected_status(input logic busy_bit);
		return wb_data_t'({ref_done, busy_bit, ref_loaded,
			kernel_count_t'(ref_sets.size())});
	endfunction

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end else begin
			return s >> 1;
		end
	endfunction

	task automatic rand16(output logic [15:0] v);
		v = '0;
		for (int i = 0; i < 16; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic note_failure(input string msg);
		$display("ERROR %s", msg);
		test_errors++;
		total_errors++;
	endtask

	task automatic expect_value(input string name, input wb_data_t exp, input wb_data_t act);
		chk_name.push_back(name);
		chk_exp.push_back(exp);
		chk_act.push_back(act);
	endtask

	// Drains queued comparisons between edges
	always @(negedge clk) begin
		while (chk_name.size() > 0) begin
			cur_name = chk_name.pop_front();
			cur_exp = chk_exp.pop_front();
			cur_act = chk_act.pop_front();
			test_checks++;
			total_checks++;
			value_match: assert (cur_act === cur_exp) else begin
				$display("MISMATCH %s: expected %h, actual %h", cur_name, cur_exp, cur_act);
				test_errors++;
				total_errors++;
			end
		end
	end

	task automatic finish_test(input string name);
		int n;
		n = 0;
		while (chk_name.size() > 0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		checks_drained: assert (chk_name.size() == 0) else
			note_failure($sformatf("checks of %s were never compared", name));
		@(posedge clk);
		#1;
		$display("%-14s %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
		tests_run++;
	endtask

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// One classic cycle, given up after limit cycles without ack
	task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
		input int limit, output wb_data_t rdat, output logic acked);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		acked = 1'b0;
		rdat = '0;
		n = 0;
		while (!acked && n < limit) begin
			@(negedge clk);
			if (wb_ack) begin
				acked = 1'b1;
				rdat = wb_dat_r;
			end
			n++;
		end
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
		wb_data_t unused;
		logic ok;
		bus_cycle(1'b1, adr, data, ACK_LIMIT, unused, ok);
		write_acked: assert (ok) else
			note_failure($sformatf("write to register %0d was never acknowledged", adr));
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
		logic ok;
		bus_cycle(1'b0, adr, '0, ACK_LIMIT, data, ok);
		read_acked: assert (ok) else
			note_failure($sformatf("read of register %0d was never acknowledged", adr));
	endtask

	//////////////////////////////////////////////////
	// Engine operations
	//////////////////////////////////////////////////

	task automatic push_weight(input logic [15:0] value);
		wb_write(REG_WEIGHT, wb_data_t'(value));
		pend_set = {value, pend_set[KBITS-1:W]};
		pend_count++;
		if (pend_count == TAPS) begin
			ref_sets.push_back(pend_set);
			pend_count = 0;
		end
	endtask

	task automatic write_random_set();
		logic [15:0] v;
		for (int i = 0; i < TAPS; i++) begin
			rand16(v);
			push_weight(v);
		end
		// Set reaches the queue one cycle after the last push
		idle_cycles(2);
	endtask

	task automatic write_pixel(input logic [15:0] value);
		wb_write(REG_PIXEL, wb_data_t'(value));
		ref_window = {value, ref_window[KBITS-1:W]};
	endtask

	task automatic write_random_pixels(input int n);
		logic [15:0] v;
		for (int i = 0; i < n; i++) begin
			rand16(v);
			write_pixel(v);
		end
	endtask

	task automatic load_kernel();
		wb_write(REG_CTRL, wb_data_t'(1 << `CONV_CTRL_LOAD_BIT));
		if (ref_sets.size() > 0) begin
			ref_active = ref_sets.pop_front();
			ref_loaded = 1'b1;
		end
	endtask

	task automatic check_status(input string name);
		wb_data_t rd;
		wb_read(REG_STATUS, rd);
		expect_value({name, " status"}, expected_status(1'b0), rd);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < DONE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		done_seen: assert (done) else note_failure("done never rose after a start");
		@(posedge clk);
		#1;
	endtask

	task automatic run_conv(input string name);
		wb_data_t rd;
		wb_write(REG_CTRL, wb_data_t'(1 << `CONV_CTRL_START_BIT));
		wait_done();
		ref_done = 1'b1;
		wb_read(REG_RESULT, rd);
		expect_value({name, " result"}, conv_ref(ref_active, ref_window), rd);
		check_status(name);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		int n;
		wb_data_t rd;
		logic [15:0] v;
		logic ok;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		lfsr_state = 32'h6fcb;
		pend_set = '0;
		pend_count = 0;
		ref_active = '0;
		ref_window = '0;
		ref_loaded = 1'b0;
		ref_done = 1'b0;
		test_checks = 0;
		test_errors = 0;
		total_checks = 0;
		total_errors = 0;
		tests_run = 0;
		n = 0;
		while (reset !== 1'b0 && n < 100) begin
			@(posedge clk);
			n++;
		end
		reset_released: assert (reset === 1'b0) else note_failure("reset was never released");
		idle_cycles(1);

		// Reset values
		wb_read(REG_STATUS, rd);
		expect_value("after_reset status", '0, rd);
		expect_value("after_reset done", '0, wb_data_t'(done));
		finish_test("after_reset");

		write_random_set();
		load_kernel();
		write_random_pixels(TAPS);
		run_conv("single_conv");
		finish_test("single_conv");

		// Four sets come back out in write order
		for (int i = 0; i < 4; i++) begin
			write_random_set();
		end
		check_status("queue_order full");
		for (int i = 0; i < 4; i++) begin
			load_kernel();
			check_status($sformatf("queue_order load %0d", i));
			run_conv($sformatf("queue_order set %0d", i));
		end
		finish_test("queue_order");

		// Ninth weight of a fifth set is held off
		for (int i = 0; i < 4; i++) begin
			write_random_set();
		end
		check_status("backpressure full");
		for (int i = 0; i < TAPS - 1; i++) begin
			rand16(v);
			push_weight(v);
		end
		rand16(v);
		bus_cycle(1'b1, REG_WEIGHT, wb_data_t'(v), STALL_LIMIT, rd, ok);
		weight_stalled: assert (!ok) else
			note_failure("weight write into a full queue was acknowledged");
		idle_cycles(1);
		load_kernel();
		check_status("backpressure after load");
		push_weight(v);
		idle_cycles(2);
		check_status("backpressure retried");
		finish_test("backpressure");

		// Drain the queue, then load once more
		for (int i = 0; i < 4; i++) begin
			load_kernel();
			check_status($sformatf("empty_load drain %0d", i));
		end
		load_kernel();
		check_status("empty_load extra");
		run_conv("empty_load");
		finish_test("empty_load");

		write_random_pixels(3);
		run_conv("sliding_window");
		finish_test("sliding_window");

		$display("Summary: %0d tests, %0d checks, %0d errors",
			tests_run, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Released just after a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* conv3x3_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv3x3_engine (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_bus_pkg::wb_addr_t wb_adr,
	input wb_bus_pkg::wb_data_t wb_dat_w,
	output wb_bus_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	output logic done
);
	import conv_types_pkg::*;

	data_t active_kernel [`CONV_KERNEL_SIZE];
	data_t window [`CONV_KERNEL_SIZE];

	tap_bus_if tap_bus ();

	assign done = tap_bus.mac_done;

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	conv_wb_regs regs_inst (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.bus(tap_bus.regs)
	);

	//////////////////////////////////////////////////
	// Buffers and MAC
	//////////////////////////////////////////////////

	conv_kernel_buffer #(
		.DEPTH(`CONV_KERNEL_DEPTH)
	) kernel_inst (
		.clk(clk),
		.reset(reset),
		.bus(tap_bus.kernel),
		.active_kernel(active_kernel)
	);

	conv_window_buffer window_inst (
		.clk(clk),
		.reset(reset),
		.bus(tap_bus.window),
		.window(window)
	);

	conv_mac_unit mac_inst (
		.clk(clk),
		.reset(reset),
		.bus(tap_bus.mac),
		.active_kernel(active_kernel),
		.window(window)
	);

endmodule

`default_nettype wire

/* conv_mac_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_mac_unit (
	input logic clk,
	input logic reset,
	tap_bus_if.mac bus,
	input conv_types_pkg::data_t active_kernel [`CONV_KERNEL_SIZE],
	input conv_types_pkg::data_t window [`CONV_KERNEL_SIZE]
);
	import conv_types_pkg::*;

	localparam tap_index_t LAST_TAP = tap_index_t'(`CONV_KERNEL_SIZE - 1);

	mac_state_t state;
	tap_index_t tap;
	acc_t acc;
	acc_t acc_next;
	logic signed [2*`CONV_DATA_WIDTH-1:0] product;

	// One signed tap product per cycle
	assign product = active_kernel[tap] * window[tap];
	assign acc_next = acc + acc_t'(product);

	assign bus.mac_busy = (state == MAC_RUN);
	assign bus.mac_done = (state == MAC_DONE);

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= MAC_IDLE;
			tap <= '0;
		end else begin
			case (state)
				MAC_IDLE, MAC_DONE: begin
					// Restart also clears done
					if (bus.mac_start) begin
						state <= MAC_RUN;
						tap <= '0;
					end
				end
				MAC_RUN: begin
					if (tap == LAST_TAP) begin
						state <= MAC_DONE;
					end else begin
						tap <= tap + 1'b1;
					end
				end
				default: state <= MAC_IDLE;
			endcase
		end
	end

	// Datapath, result lands with done
	always_ff @(posedge clk) begin
		if (bus.mac_start) begin
			acc <= '0;
		end else if (state == MAC_RUN) begin
			acc <= acc_next;
			if (tap == LAST_TAP) begin
				bus.result <= acc_next;
			end
		end
	end

	// Register block holds ctrl writes while busy
	no_start_while_running: assert property (@(posedge clk) disable iff (reset)
		bus.mac_start |-> state != MAC_RUN);

endmodule

`default_nettype wire

/* conv_window_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_window_buffer (
	input logic clk,
	input logic reset,
	tap_bus_if.window bus,
	output conv_types_pkg::data_t window [`CONV_KERNEL_SIZE]
);
	import conv_types_pkg::*;

	localparam tap_index_t FULL_FILL = tap_index_t'(`CONV_KERNEL_SIZE);

	tap_index_t fill;

	// Slide by one pixel per push
	always_ff @(posedge clk) begin
		if (bus.pixel_push) begin
			for (int i = 0; i < `CONV_KERNEL_SIZE - 1; i++) begin
				window[i] <= window[i + 1];
			end
			window[`CONV_KERNEL_SIZE - 1] <= bus.wdata;
		end
	end

	// Saturates once the first full window is in
	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
		end else if (bus.pixel_push && fill != FULL_FILL) begin
			fill <= fill + 1'b1;
		end
	end

	// A convolution only runs on a complete window
	start_on_full_window: assert property (@(posedge clk) disable iff (reset)
		bus.mac_start |-> fill == FULL_FILL);

endmodule

`default_nettype wire

/* conv_kernel_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_kernel_buffer #(
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	tap_bus_if.kernel bus,
	output conv_types_pkg::data_t active_kernel [`CONV_KERNEL_SIZE]
);
	import conv_types_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam tap_index_t LAST_TAP = tap_index_t'(`CONV_KERNEL_SIZE - 1);

	data_t chain [`CONV_KERNEL_SIZE];
	data_t queue [DEPTH][`CONV_KERNEL_SIZE];
	tap_index_t push_count;
	logic set_done;
	kernel_count_t count;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic full;
	logic do_load;

	assign full = (count == kernel_count_t'(DEPTH));
	assign do_load = bus.kernel_load && (count != '0);

	// Hold the ninth weight while no slot is free
	assign bus.weight_ready = !(full && push_count == LAST_TAP);
	assign bus.kernel_count = count;

	//////////////////////////////////////////////////
	// Weight shift chain
	//////////////////////////////////////////////////

	// New weight enters at the top, first one ends at tap 0
	always_ff @(posedge clk) begin
		if (bus.weight_push) begin
			for (int i = 0; i < `CONV_KERNEL_SIZE - 1; i++) begin
				chain[i] <= chain[i + 1];
			end
			chain[`CONV_KERNEL_SIZE - 1] <= bus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			push_count <= '0;
			set_done <= 1'b0;
		end else begin
			set_done <= bus.weight_push && (push_count == LAST_TAP);
			if (bus.weight_push) begin
				push_count <= (push_count == LAST_TAP) ? '0 : push_count + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Kernel set queue
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (set_done) begin
			queue[wr_ptr] <= chain;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			bus.kernel_loaded <= 1'b0;
		end else begin
			if (set_done) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_load) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				bus.kernel_loaded <= 1'b1;
			end
			case ({set_done, do_load})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Active kernel, empty-queue loads are ignored
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CONV_KERNEL_SIZE; i++) begin
				active_kernel[i] <= '0;
			end
		end else if (do_load) begin
			active_kernel <= queue[rd_ptr];
		end
	end

	// Back-pressure in the register block keeps the queue from overflowing
	no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		set_done |-> !full);

endmodule

`default_nettype wire

/* conv_wb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_wb_regs (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_bus_pkg::wb_addr_t wb_adr,
	input wb_bus_pkg::wb_data_t wb_dat_w,
	output wb_bus_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	tap_bus_if.regs bus
);
	import wb_bus_pkg::*;
	import conv_types_pkg::*;

	logic req;
	logic stall;
	logic accept;
	logic wr_weight;
	logic wr_pixel;
	logic wr_ctrl;
	wb_data_t read_data;

	// New request only when no ack is pending
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign accept = req && !stall;

	assign wr_weight = wb_we && (wb_adr == REG_WEIGHT);
	assign wr_pixel = wb_we && (wb_adr == REG_PIXEL);
	assign wr_ctrl = wb_we && (wb_adr == REG_CTRL);

	//////////////////////////////////////////////////
	// Back-pressure
	//////////////////////////////////////////////////

	// Weight waits on the queue, pixel and ctrl on the MAC
	always_comb begin
		stall = 1'b0;
		if (wr_weight) begin
			stall = !bus.weight_ready;
		end else if (wr_pixel || wr_ctrl) begin
			stall = bus.mac_busy;
		end
	end

	// Read mux
	always_comb begin
		read_data = '0;
		case (wb_adr)
			REG_STATUS: begin
				read_data = wb_data_t'({bus.mac_done, bus.mac_busy,
					bus.kernel_loaded, bus.kernel_count});
			end
			REG_RESULT: read_data = wb_data_t'(bus.result);
			default: read_data = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Ack and pulses
	//////////////////////////////////////////////////

	// Pulses share the ack cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			bus.weight_push <= 1'b0;
			bus.pixel_push <= 1'b0;
			bus.kernel_load <= 1'b0;
			bus.mac_start <= 1'b0;
		end else begin
			wb_ack <= accept;
			bus.weight_push <= accept && wr_weight;
			bus.pixel_push <= accept && wr_pixel;
			bus.kernel_load <= accept && wr_ctrl && wb_dat_w[`CONV_CTRL_LOAD_BIT];
			bus.mac_start <= accept && wr_ctrl && wb_dat_w[`CONV_CTRL_START_BIT];
		end
	end

	// Write data and read data, valid with ack
	always_ff @(posedge clk) begin
		if (accept) begin
			bus.wdata <= data_t'(wb_dat_w[`CONV_DATA_WIDTH-1:0]);
			wb_dat_r <= read_data;
		end
	end

	// Classic cycle, ack is a single pulse
	ack_single_pulse: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* tap_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface tap_bus_if;
	import conv_types_pkg::*;

	// One-cycle pulses from the register block
	logic weight_push;
	logic pixel_push;
	logic kernel_load;
	logic mac_start;
	data_t wdata;

	// Kernel buffer status
	logic weight_ready;
	kernel_count_t kernel_count;
	logic kernel_loaded;

	// MAC status and result
	logic mac_busy;
	logic mac_done;
	acc_t result;

	modport regs (
		output weight_push,
		output pixel_push,
		output kernel_load,
		output mac_start,
		output wdata,
		input weight_ready,
		input kernel_count,
		input kernel_loaded,
		input mac_busy,
		input mac_done,
		input result
	);

	modport kernel (
		input weight_push,
		input kernel_load,
		input wdata,
		output weight_ready,
		output kernel_count,
		output kernel_loaded
	);

	modport window (
		input pixel_push,
		input mac_start,
		input wdata
	);

	modport mac (
		input mac_start,
		output mac_busy,
		output mac_done,
		output result
	);

endinterface

`default_nettype wire

/* wb_bus_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package wb_bus_pkg;

	typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

	// Word address, no byte lanes
	typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;

	// Register map of the engine
	typedef enum logic [`WB_ADDR_WIDTH-1:0] {
		REG_WEIGHT = `CONV_REG_WEIGHT,
		REG_PIXEL = `CONV_REG_PIXEL,
		REG_CTRL = `CONV_REG_CTRL,
		REG_STATUS = `CONV_REG_STATUS,
		REG_RESULT = `CONV_REG_RESULT
	} reg_index_t;

endpackage

`default_nettype wire

/* conv_types_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_types_pkg;

	// One weight or one pixel
	typedef logic signed [`CONV_DATA_WIDTH-1:0] data_t;

	// Accumulator, wraps modulo 2**32
	typedef logic [`CONV_ACC_WIDTH-1:0] acc_t;

	// Tap select, also used as a push and fill counter
	typedef logic [3:0] tap_index_t;

	// Number of queued kernel sets, 0..4
	typedef logic [2:0] kernel_count_t;

	// Sequential MAC
	typedef enum logic [1:0] {
		MAC_IDLE,
		MAC_RUN,
		MAC_DONE
	} mac_state_t;

endpackage

`default_nettype wire

/* conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

`define CONV_DATA_WIDTH 16
`define CONV_ACC_WIDTH 32

// 3x3 kernel, taps numbered 0..8
`define CONV_KERNEL_SIZE 9
`define CONV_KERNEL_DEPTH 4

//////////////////////////////////////////////////
// Wishbone side
//////////////////////////////////////////////////

`define WB_DATA_WIDTH 32
`define WB_ADDR_WIDTH 4

// Word addresses of the register map
`define CONV_REG_WEIGHT 0
`define CONV_REG_PIXEL 1
`define CONV_REG_CTRL 2
`define CONV_REG_STATUS 3
`define CONV_REG_RESULT 4

// CTRL write bits
`define CONV_CTRL_LOAD_BIT 0
`define CONV_CTRL_START_BIT 1

`endif
